// ==== build.f ====
rtl/mcu_isa_pkg.sv
rtl/mcu_bus_pkg.sv
rtl/mcu_sequencer.sv
rtl/mcu_reg_bank.sv
rtl/mcu_return_stack.sv
rtl/mcu_bus_master.sv
rtl/mcu_top.sv
verification/mcu_assertions.sv
verification/mcu_tb.sv

// ==== program.hex ====
// one 16-bit code word per line, hex: opcode nibble, dst nibble, src index or immediate byte
// opcodes 0 movi, 1 mov, 2 add, 3 jnz, 4 jmp
00C8 // movi r0, 0xc8
015A // movi r1, 0x5a
2001 // add r0, r1 -> 0x0122
1900 // mov leds, r0 -> 0x22
0211 // movi r2, 0x11
1802 // mov rstk, r2
0822 // movi rstk, 0x22
0833 // movi rstk, 0x33
0B10 // movi av_addr, 0x10
1A08 // mov av_wdata, rstk (pop 0x33)
0C01 // movi av_ctrl, 1
1A08 // mov av_wdata, rstk (pop 0x22)
0B11 // movi av_addr, 0x11
0C01 // movi av_ctrl, 1
1A08 // mov av_wdata, rstk (pop 0x11)
0B12 // movi av_addr, 0x12
0C01 // movi av_ctrl, 1
07FF // movi r7, 0xff
1607 // mov r6, r7
2707 // add r7, r7 (x8 -> 0xff00)
2707
2707
2707
2707
2707
2707
2707
2706 // add r7, r6 -> 0xffff, used as minus one
0504 // movi r5, 4
0B20 // movi av_addr, 0x20
1A05 // loop: mov av_wdata, r5
0C01 // movi av_ctrl, 1
2507 // add r5, r7 (decrement by wraparound)
351E // jnz r5, loop
140E // mov r4, sr_keys
2400 // add r4, r0
1904 // mov leds, r4
0BFF // movi av_addr, 0xff
1A0E // mov av_wdata, sr_keys
0C01 // movi av_ctrl, 1
4028 // jmp to self

// ==== rtl/mcu_bus_master.sv ====
`timescale 1ns/1ps

module mcu_bus_master (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  mcu_bus_pkg::reg_wr_t reg_wr,
    input  logic                 waitrequest,
    output mcu_bus_pkg::av_req_t av_req,
    output logic                 bus_busy
);
    import mcu_isa_pkg::*;

    logic [15:0] address;
    logic [15:0] writedata;
    logic        write;
    logic        accept;

    // transfer taken on an edge where waitrequest is low
    assign accept = write && !waitrequest;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            address   <= '0;
            writedata <= '0;
            write     <= 1'b0;
        end else begin
            if (accept) begin
                write <= 1'b0;
            end else if (reg_wr.valid && (reg_wr.index == reg_av_ctrl) && reg_wr.data[0]) begin
                write <= 1'b1;
            end
            // address and data frozen while a write is pending
            if (reg_wr.valid && !write) begin
                if (reg_wr.index == reg_av_addr) begin
                    address <= reg_wr.data;
                end
                if (reg_wr.index == reg_av_wdata) begin
                    writedata <= reg_wr.data;
                end
            end
        end
    end

    assign av_req   = '{write: write, address: address, writedata: writedata};
    // sequencer holds in bus-wait while this is high
    assign bus_busy = write;

endmodule

// ==== rtl/mcu_bus_pkg.sv ====
package mcu_bus_pkg;

    // one register write per execute cycle, broadcast to every datapath
    typedef struct packed {
        logic        valid;
        logic [3:0]  index;
        logic [15:0] data;
    } reg_wr_t;

    // bus master request; also read back through the mapped registers
    typedef struct packed {
        logic        write;
        logic [15:0] address;
        logic [15:0] writedata;
    } av_req_t;

endpackage

// ==== rtl/mcu_isa_pkg.sv ====
package mcu_isa_pkg;

    // opcode lives in the top nibble of each code word
    typedef enum logic [3:0] {
        op_movi = 4'h0,
        op_mov  = 4'h1,
        op_add  = 4'h2,
        op_jnz  = 4'h3,
        op_jmp  = 4'h4
    } opcode_t;

    // low byte is a source index or an 8-bit immediate, depending on opcode
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] dst;
        logic [7:0] src_imm;
    } instr_t;

    // sequencer states
    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_bus_wait
    } state_t;

    // mapped register indices
    localparam logic [3:0] reg_gp0      = 4'd0;
    localparam logic [3:0] reg_gp1      = 4'd1;
    localparam logic [3:0] reg_gp2      = 4'd2;
    localparam logic [3:0] reg_gp3      = 4'd3;
    localparam logic [3:0] reg_gp4      = 4'd4;
    localparam logic [3:0] reg_gp5      = 4'd5;
    localparam logic [3:0] reg_gp6      = 4'd6;
    localparam logic [3:0] reg_gp7      = 4'd7;
    localparam logic [3:0] reg_rstk     = 4'd8;
    localparam logic [3:0] reg_leds     = 4'd9;
    localparam logic [3:0] reg_av_wdata = 4'd10;
    localparam logic [3:0] reg_av_addr  = 4'd11;
    // bit 0 starts a bus write
    localparam logic [3:0] reg_av_ctrl  = 4'd12;
    // status registers, read only
    localparam logic [3:0] reg_sr_wait  = 4'd13;
    localparam logic [3:0] reg_sr_keys  = 4'd14;

endpackage

// ==== rtl/mcu_reg_bank.sv ====
`timescale 1ns/1ps

module mcu_reg_bank (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  mcu_bus_pkg::reg_wr_t reg_wr,
    input  logic [3:0]           rd_index,
    input  logic [15:0]          stack_top,
    input  mcu_bus_pkg::av_req_t bus_regs,
    input  logic                 waitrequest,
    input  logic [1:0]           keys,
    output logic [15:0]          rd_data,
    output logic [7:0]           leds
);
    import mcu_isa_pkg::*;

    logic [15:0] gp [8];
    logic        gp_wr;
    logic        led_wr;

    // own index decode
    assign gp_wr  = reg_wr.valid && (reg_wr.index inside {[reg_gp0:reg_gp7]});
    assign led_wr = reg_wr.valid && (reg_wr.index == reg_leds);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            gp   <= '{default: '0};
            leds <= '0;
        end else begin
            if (gp_wr) begin
                gp[reg_wr.index[2:0]] <= reg_wr.data;
            end
            // only the low byte drives the pins
            if (led_wr) begin
                leds <= reg_wr.data[7:0];
            end
        end
    end

    // read mux over every mapped register
    always_comb begin
        case (rd_index) inside
            [reg_gp0:reg_gp7]: rd_data = gp[rd_index[2:0]];
            reg_rstk:          rd_data = stack_top;
            reg_leds:          rd_data = {8'h00, leds};
            reg_av_wdata:      rd_data = bus_regs.writedata;
            reg_av_addr:       rd_data = bus_regs.address;
            reg_av_ctrl:       rd_data = {15'h0000, bus_regs.write};
            // status inputs, zero-extended
            reg_sr_wait:       rd_data = {15'h0000, waitrequest};
            reg_sr_keys:       rd_data = {14'h0000, keys};
            default:           rd_data = 16'h0000;
        endcase
    end

endmodule

// ==== rtl/mcu_return_stack.sv ====
`timescale 1ns/1ps

module mcu_return_stack #(
    parameter int STACK_DEPTH = 8
) (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  mcu_bus_pkg::reg_wr_t reg_wr,
    input  logic                 pop,
    output logic [15:0]          stack_top
);
    import mcu_isa_pkg::*;

    localparam int PTR_W = $clog2(STACK_DEPTH);

    logic [15:0]    mem [STACK_DEPTH];
    // entry count, 0 to STACK_DEPTH
    logic [PTR_W:0] sp;
    logic           push_req;
    logic           pop_ok;
    logic           full;
    logic           empty;

    assign push_req = reg_wr.valid && (reg_wr.index == reg_rstk);
    assign empty    = (sp == '0);
    assign full     = (sp == (PTR_W+1)'(STACK_DEPTH));
    // popping nothing is a no-op
    assign pop_ok   = pop && !empty;

    // empty stack reads as zero
    assign stack_top = empty ? 16'h0000 : mem[PTR_W'(sp - 1'b1)];

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            sp <= '0;
        end else if (push_req && !pop_ok && !full) begin
            sp <= sp + 1'b1;
        end else if (pop_ok && !push_req) begin
            sp <= sp - 1'b1;
        end
    end

    // pop and push together replace the top in place
    // a push onto a full stack is lost
    always_ff @(posedge sysclk) begin
        if (push_req && pop_ok) begin
            mem[PTR_W'(sp - 1'b1)] <= reg_wr.data;
        end else if (push_req && !full) begin
            mem[PTR_W'(sp)] <= reg_wr.data;
        end
    end

endmodule

// ==== rtl/mcu_sequencer.sv ====
`timescale 1ns/1ps

module mcu_sequencer #(
    parameter int ROM_DEPTH = 64
) (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic                 bus_busy,
    input  logic [15:0]          rd_data,
    output logic [3:0]           rd_index,
    output logic                 pop,
    output mcu_bus_pkg::reg_wr_t reg_wr
);
    import mcu_isa_pkg::*;

    localparam int PC_W = $clog2(ROM_DEPTH);

    logic [15:0]     rom [ROM_DEPTH];
    logic [PC_W-1:0] pc;
    state_t          state;
    instr_t          fetch_word;
    instr_t          ir;
    // dst operand, captured during fetch
    logic [15:0]     acc;
    logic [15:0]     result;
    logic            wr_en;
    logic            jump;
    logic            bus_start;

    // code memory image
    initial begin
        $readmemh("program.hex", rom);
    end

    assign fetch_word = instr_t'(rom[pc]);

    // single read port
    // fetch reads dst of the word at pc, execute reads src of the latched word
    assign rd_index = (state == st_fetch) ? fetch_word.dst : ir.src_imm[3:0];

    // execute decode
    always_comb begin
        result = 16'h0000;
        wr_en  = 1'b0;
        jump   = 1'b0;
        pop    = 1'b0;
        if (state == st_exec) begin
            case (ir.opcode)
                op_movi: begin
                    result = {8'h00, ir.src_imm};
                    wr_en  = 1'b1;
                end
                op_mov: begin
                    result = rd_data;
                    wr_en  = 1'b1;
                    // reading the stack consumes its top
                    pop    = (ir.src_imm[3:0] == reg_rstk);
                end
                op_add: begin
                    // wraps at 16 bits
                    result = acc + rd_data;
                    wr_en  = 1'b1;
                    pop    = (ir.src_imm[3:0] == reg_rstk);
                end
                op_jnz: jump = (acc != 16'h0000);
                op_jmp: jump = 1'b1;
                // undefined opcodes fall through as no-ops
                default: jump = 1'b0;
            endcase
        end
    end

    assign reg_wr = '{valid: wr_en, index: ir.dst, data: result};

    // a ctrl write with bit 0 set launches a bus transfer
    assign bus_start = wr_en && (ir.dst == reg_av_ctrl) && result[0];

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_fetch;
            pc    <= '0;
        end else begin
            case (state)
                st_fetch: state <= st_exec;
                st_exec: begin
                    // branch target is the immediate, truncated to the pc width
                    pc    <= jump ? ir.src_imm[PC_W-1:0] : pc + PC_W'(1);
                    state <= bus_start ? st_bus_wait : st_fetch;
                end
                st_bus_wait: begin
                    // core stalls until the transfer is accepted
                    if (!bus_busy) begin
                        state <= st_fetch;
                    end
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // instruction and operand latch
    always_ff @(posedge sysclk) begin
        if (state == st_fetch) begin
            ir  <= fetch_word;
            acc <= rd_data;
        end
    end

endmodule

// ==== rtl/mcu_top.sv ====
`timescale 1ns/1ps

module mcu_top #(
    parameter int STACK_DEPTH = 8,
    parameter int ROM_DEPTH   = 64
) (
    input  logic                 sysclk,
    input  logic                 arst_n,
    input  logic [1:0]           keys,
    input  logic                 waitrequest,
    output logic [7:0]           leds,
    output mcu_bus_pkg::av_req_t av_req
);
    import mcu_bus_pkg::*;

    // broadcast write from the sequencer
    reg_wr_t     reg_wr;
    logic [3:0]  rd_index;
    logic [15:0] rd_data;
    logic        pop;
    logic [15:0] stack_top;
    logic        bus_busy;

    mcu_sequencer #(
        .ROM_DEPTH(ROM_DEPTH)
    ) seq_i (
        .sysclk   (sysclk),
        .arst_n   (arst_n),
        .bus_busy (bus_busy),
        .rd_data  (rd_data),
        .rd_index (rd_index),
        .pop      (pop),
        .reg_wr   (reg_wr)
    );

    // bus registers read back straight from the request outputs
    mcu_reg_bank regs_i (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .reg_wr      (reg_wr),
        .rd_index    (rd_index),
        .stack_top   (stack_top),
        .bus_regs    (av_req),
        .waitrequest (waitrequest),
        .keys        (keys),
        .rd_data     (rd_data),
        .leds        (leds)
    );

    mcu_return_stack #(
        .STACK_DEPTH(STACK_DEPTH)
    ) rstk_i (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_wr    (reg_wr),
        .pop       (pop),
        .stack_top (stack_top)
    );

    mcu_bus_master bus_i (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .reg_wr      (reg_wr),
        .waitrequest (waitrequest),
        .av_req      (av_req),
        .bus_busy    (bus_busy)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the MCU testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mcu_tb -f build.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vmcu_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF 'All tests passed!'; then
    exit 0
fi
exit 1

// ==== verification/mcu_assertions.sv ====
`timescale 1ns/1ps

module mcu_assertions (
    input logic                 sysclk,
    input logic                 arst_n,
    input logic                 waitrequest,
    input mcu_bus_pkg::av_req_t av_req
);

    // count of failed assertions
    int unsigned fail_count = 0;

    // stalled request keeps write, address and data
    hold_on_wait: assert property (
        @(posedge sysclk) disable iff (!arst_n)
        av_req.write && waitrequest |=> av_req.write && $stable(av_req.address)
            && $stable(av_req.writedata)
    ) else begin
        $error("bus request changed while waitrequest was high");
        fail_count++;
    end

    // one accept edge per transfer
    drop_after_accept: assert property (
        @(posedge sysclk) disable iff (!arst_n)
        av_req.write && !waitrequest |=> !av_req.write
    ) else begin
        $error("bus write still high after it was accepted");
        fail_count++;
    end

    // no request during or right after reset
    idle_in_reset: assert property (
        @(posedge sysclk) !arst_n || $rose(arst_n) |-> !av_req.write
    ) else begin
        $error("bus write high during or just after reset");
        fail_count++;
    end

endmodule

// ==== verification/mcu_tb.sv ====
`timescale 1ns/1ps

module mcu_tb;
    import mcu_isa_pkg::*;
    import mcu_bus_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int STACK_DEPTH  = 8;
    localparam int ROM_DEPTH    = 64;
    // model gives up on a program without a self-jump
    localparam int MAX_STEPS    = 4096;

    logic        sysclk;
    logic        arst_n;
    logic [1:0]  keys;
    logic        waitrequest;
    logic [7:0]  leds;
    av_req_t     av_req;

    logic [31:0] rng;
    logic [31:0] rnd;
    logic [1:0]  key_val;
    logic [15:0] code [ROM_DEPTH];

    // reference model state
    logic [15:0] model_gp [8];
    logic [15:0] model_stack [$];
    logic [15:0] model_wdata;
    logic [15:0] model_addr;
    logic [7:0]  model_leds;

    av_req_t     exp_bus [$];
    av_req_t     exp_req;
    logic [7:0]  exp_leds;
    int          ref_steps;
    int          exp_writes;
    int          bus_seen;
    int          cycles;
    int          cycle_limit;
    int          value_errors;
    int          other_errors;
    int          assert_errors;

    mcu_top #(
        .STACK_DEPTH(STACK_DEPTH),
        .ROM_DEPTH  (ROM_DEPTH)
    ) mcu_i (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .keys        (keys),
        .waitrequest (waitrequest),
        .leds        (leds),
        .av_req      (av_req)
    );

    bind mcu_top mcu_assertions assert_i (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .av_req      (av_req)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
    end

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // what a read of a mapped register returns without side effects
    function automatic logic [15:0] peek_reg(input logic [3:0] idx, input logic [1:0] key_in);
        if (idx <= reg_gp7) begin
            return model_gp[idx[2:0]];
        end
        case (idx)
            reg_rstk:     return (model_stack.size() == 0) ? 16'h0000 : model_stack[$];
            reg_leds:     return {8'h00, model_leds};
            reg_av_wdata: return model_wdata;
            reg_av_addr:  return model_addr;
            reg_sr_keys:  return {14'h0000, key_in};
            // ctrl reads as idle between transfers and sr_wait is never read
            default:      return 16'h0000;
        endcase
    endfunction

    // reading the stack in execute consumes its top
    function automatic void pop_on_read(input logic [3:0] idx);
        if (idx == reg_rstk && model_stack.size() > 0) begin
            void'(model_stack.pop_back());
        end
    endfunction

    function automatic void write_model(input logic [3:0] idx, input logic [15:0] data);
        if (idx <= reg_gp7) begin
            model_gp[idx[2:0]] = data;
        end else begin
            case (idx)
                reg_rstk: begin
                    // full stack drops the push
                    if (model_stack.size() < STACK_DEPTH) begin
                        model_stack.push_back(data);
                    end
                end
                reg_leds:     model_leds = data[7:0];
                reg_av_wdata: model_wdata = data;
                reg_av_addr:  model_addr = data;
                reg_av_ctrl: begin
                    if (data[0]) begin
                        exp_bus.push_back('{write: 1'b1, address: model_addr,
                                            writedata: model_wdata});
                    end
                end
                default: ;
            endcase
        end
    endfunction

    // interprets the code image up to its self-jump and returns the step count
    function automatic int run_reference(input logic [1:0] key_in);
        instr_t      ins;
        logic [15:0] dst_val;
        logic [15:0] src_val;
        int          pc;
        int          next_pc;
        int          steps;
        bit          halted;
        pc     = 0;
        steps  = 0;
        halted = 1'b0;
        model_gp    = '{default: '0};
        model_wdata = '0;
        model_addr  = '0;
        model_leds  = '0;
        model_stack.delete();
        exp_bus.delete();
        while (!halted && steps < MAX_STEPS) begin
            ins     = instr_t'(code[pc]);
            dst_val = peek_reg(ins.dst, key_in);
            src_val = peek_reg(ins.src_imm[3:0], key_in);
            next_pc = (pc + 1) % ROM_DEPTH;
            steps++;
            case (ins.opcode)
                op_movi: write_model(ins.dst, {8'h00, ins.src_imm});
                op_mov: begin
                    pop_on_read(ins.src_imm[3:0]);
                    write_model(ins.dst, src_val);
                end
                op_add: begin
                    pop_on_read(ins.src_imm[3:0]);
                    // sum wraps at 16 bits
                    write_model(ins.dst, 16'(dst_val + src_val));
                end
                op_jnz: begin
                    if (dst_val != 16'h0000) begin
                        next_pc = int'(ins.src_imm) % ROM_DEPTH;
                    end
                end
                op_jmp: begin
                    next_pc = int'(ins.src_imm) % ROM_DEPTH;
                    halted  = (next_pc == pc);
                end
                default: ;
            endcase
            pc = next_pc;
        end
        exp_leds = model_leds;
        return steps;
    endfunction

    task automatic check_bus(input string name, input av_req_t expected, input av_req_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected addr=%h data=%h write=%b, actual addr=%h data=%h write=%b",
                     name, expected.address, expected.writedata, expected.write,
                     actual.address, actual.writedata, actual.write);
            value_errors++;
        end
    endtask

    task automatic check_leds(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    // random back-pressure and keys held at the model's value
    always @(negedge sysclk) begin
        rnd = lcg_next();
        waitrequest <= rnd[16];
        keys        <= key_val;
    end

    // sampled mid low phase ahead of the accept edge
    always @(negedge sysclk) begin
        #(CLK_PERIOD / 4);
        if (arst_n && av_req.write && !waitrequest) begin
            if (exp_bus.size() == 0) begin
                $display("unexpected extra bus write to address %h with data %h",
                         av_req.address, av_req.writedata);
                other_errors++;
            end else begin
                exp_req = exp_bus.pop_front();
                check_bus($sformatf("bus write %0d", bus_seen), exp_req, av_req);
            end
            bus_seen++;
        end
    end

    initial begin
        sysclk       = 1'b0;
        arst_n       = 1'b0;
        keys         = 2'b00;
        waitrequest  = 1'b0;
        cycles       = 0;
        bus_seen     = 0;
        value_errors = 0;
        other_errors = 0;
        rng          = 32'hc3e0;
        rnd          = lcg_next();
        // top bits of the first draw give a nonzero keys pattern
        key_val      = rnd[31:30];
        $readmemh("program.hex", code);
        ref_steps   = run_reference(key_val);
        exp_writes  = exp_bus.size();
        cycle_limit = 40 * ref_steps + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge sysclk);
        arst_n = 1'b1;

        // last write of the program precedes its self-jump
        while (bus_seen < exp_writes && cycles < cycle_limit) begin
            @(negedge sysclk);
        end
        if (bus_seen < exp_writes) begin
            $display("timeout: only %0d of %0d bus writes seen after %0d cycles",
                     bus_seen, exp_writes, cycles);
            other_errors++;
        end
        repeat (4) @(negedge sysclk);
        check_leds("final leds", exp_leds, leds);

        assert_errors = int'(mcu_i.assert_i.fail_count);
        $display("error counts: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
